//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := mmu_tb
FILELIST  := sim.f
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

//--- design/itlb.sv
module itlb (
    input  logic              clk,
    input  logic              rst_n,

    // Refill from the walker
    input  mmu_pkg::ptw2tlb_s ptw2tlb,
    input  logic              tlb_update,

    // Probe from the lookup stage
    input  mmu_pkg::mmu2tlb_s mmu2tlb,
    output mmu_pkg::tlb2mmu_s tlb2mmu
);

    mmu_pkg::tlb_entry_s [mmu_pkg::TLB_ENTRIES-1:0] tlb_array_q;
    mmu_pkg::tlb_entry_s [mmu_pkg::TLB_ENTRIES-1:0] tlb_array_d;

    logic [mmu_pkg::TLB_IDX_W-1:0] probe_idx;
    logic [mmu_pkg::TLB_IDX_W-1:0] fill_idx;
    logic [9:0]                    probe_vpn_1;
    logic [9:0]                    probe_vpn_0;
    mmu_pkg::tlb_entry_s           probe_entry;

    // Low vpn bits select the set
    assign probe_idx   = mmu2tlb.vpage_addr[mmu_pkg::TLB_IDX_W-1:0];
    assign fill_idx    = ptw2tlb.vpn[mmu_pkg::TLB_IDX_W-1:0];
    assign probe_vpn_1 = mmu2tlb.vpage_addr[19:10];
    assign probe_vpn_0 = mmu2tlb.vpage_addr[9:0];
    assign probe_entry = tlb_array_q[probe_idx];

    // Purely combinational lookup
    always_comb begin
        tlb2mmu = '0;
        if (mmu2tlb.tlb_req && probe_entry.valid && (probe_entry.vpn_1 == probe_vpn_1)) begin
            // Superpage ignores vpn_0
            if (probe_entry.page_4M || (probe_entry.vpn_0 == probe_vpn_0)) begin
                tlb2mmu.pte     = probe_entry.pte;
                tlb2mmu.hit     = 1'b1;
                tlb2mmu.page_4M = probe_entry.page_4M;
            end
        end
    end

    always_comb begin
        tlb_array_d = tlb_array_q;
        if (mmu2tlb.tlb_flush) begin    // Flush wins over a refill
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                tlb_array_d[i].valid = 1'b0;
            end
        end else if (tlb_update) begin
            tlb_array_d[fill_idx].valid   = 1'b1;
            tlb_array_d[fill_idx].vpn_1   = ptw2tlb.vpn[19:10];
            tlb_array_d[fill_idx].vpn_0   = ptw2tlb.vpn[9:0];
            tlb_array_d[fill_idx].page_4M = ptw2tlb.page_4M;
            tlb_array_d[fill_idx].pte     = ptw2tlb.pte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                tlb_array_q[i].valid <= 1'b0;
            end
        end else begin
            tlb_array_q <= tlb_array_d;
        end
    end

    // Every entry is gone in the cycle after a flush
    no_hit_after_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        mmu2tlb.tlb_flush |=> !tlb2mmu.hit
    );

endmodule

//--- design/mmu_pkg.sv
package mmu_pkg;

    localparam int TLB_ENTRIES   = 4;
    localparam int TLB_IDX_W     = $clog2(TLB_ENTRIES);
    localparam int VPN_W         = 20;
    localparam int PPN_W         = 22;
    localparam int PADDR_W       = 34;
    localparam int TAG_W         = 4;
    localparam int PAGE_OFFSET_W = 12;

    // Sv32 page table entry, bit 0 is v
    typedef struct packed {
        logic [11:0] ppn_1;
        logic [9:0]  ppn_0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_s;

    typedef struct packed {
        logic [VPN_W-1:0] vpage_addr;
        logic             tlb_req;
        logic             tlb_flush;   // Invalidate all entries
    } mmu2tlb_s;

    typedef struct packed {
        pte_s pte;
        logic hit;
        logic page_4M;
    } tlb2mmu_s;

    typedef struct packed {
        logic [VPN_W-1:0] vpn;
        pte_s             pte;
        logic             page_4M;
    } ptw2tlb_s;

    typedef struct packed {
        logic       valid;
        logic [9:0] vpn_1;
        logic [9:0] vpn_0;
        logic       page_4M;
        pte_s       pte;
    } tlb_entry_s;

    typedef struct packed {
        logic [31:0]      vaddr;
        logic [TAG_W-1:0] tag;
    } xlate_req_s;

    typedef struct packed {
        logic [VPN_W-1:0] vpn;
    } walk_req_s;

    typedef struct packed {
        logic done;
        logic fault;
        pte_s pte;
        logic page_4M;
    } walk_rsp_s;

    typedef struct packed {
        logic [31:0]      vaddr;
        logic [TAG_W-1:0] tag;
        pte_s             pte;
        logic             page_4M;
        logic             walk_fault;
    } check_in_s;

    typedef enum logic [1:0] {
        CAUSE_NONE = 2'd0,
        CAUSE_WALK = 2'd1,
        CAUSE_EXEC = 2'd2,
        CAUSE_USER = 2'd3
    } fault_cause_e;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [PADDR_W-1:0] paddr;
        logic               page_fault;
        fault_cause_e       fault_cause;
    } xlate_rsp_s;

endpackage

//--- design/mmu_top.sv
module mmu_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        req,
    input  mmu_pkg::xlate_req_s         req_data,
    output logic                        ready,

    input  logic                        flush,
    input  logic [mmu_pkg::PPN_W-1:0]   satp_ppn,
    input  logic                        priv_user,

    output logic                        mem_req,
    output logic [31:0]                 mem_addr,
    input  logic                        mem_rvalid,
    input  logic [31:0]                 mem_rdata,

    output logic                        rsp_valid,
    output mmu_pkg::xlate_rsp_s         rsp_data
);

    logic                walk_start;
    mmu_pkg::walk_req_s  walk_req;
    mmu_pkg::walk_rsp_s  walk_rsp;
    logic                tlb_update;
    mmu_pkg::ptw2tlb_s   ptw2tlb;
    logic                check_valid;
    mmu_pkg::check_in_s  check_in;

    xlate_lookup_stage xlate_lookup_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_data    (req_data),
        .ready       (ready),
        .flush       (flush),
        .walk_start  (walk_start),
        .walk_req    (walk_req),
        .walk_rsp    (walk_rsp),
        .tlb_update  (tlb_update),
        .ptw2tlb     (ptw2tlb),
        .check_valid (check_valid),
        .check_in    (check_in)
    );

    ptw ptw_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .satp_ppn   (satp_ppn),
        .walk_start (walk_start),
        .walk_req   (walk_req),
        .walk_rsp   (walk_rsp),
        .tlb_update (tlb_update),
        .ptw2tlb    (ptw2tlb),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    xlate_check_stage xlate_check_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .priv_user   (priv_user),
        .check_valid (check_valid),
        .check_in    (check_in),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data)
    );

endmodule

//--- design/ptw.sv
module ptw (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mmu_pkg::PPN_W-1:0]       satp_ppn,

    input  logic                            walk_start,
    input  mmu_pkg::walk_req_s              walk_req,
    output mmu_pkg::walk_rsp_s              walk_rsp,

    // iTLB refill
    output logic                            tlb_update,
    output mmu_pkg::ptw2tlb_s               ptw2tlb,

    // Page table memory
    output logic                            mem_req,
    output logic [31:0]                     mem_addr,
    input  logic                            mem_rvalid,
    input  logic [31:0]                     mem_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_L1,
        WAIT_L0
    } state_e;

    state_e                        state_q;
    logic                          mem_req_q;
    logic                          done_q;
    logic                          update_q;
    logic                          outstanding_q;

    logic [mmu_pkg::VPN_W-1:0]     vpn_q;
    logic [31:0]                   mem_addr_q;
    logic                          fault_q;
    mmu_pkg::pte_s                 pte_q;
    logic                          page_4m_q;

    mmu_pkg::pte_s                 rd_pte;
    logic                          rd_bad;
    logic                          rd_leaf;
    logic                          walk_fail;
    logic                          descend;
    logic                          start;
    logic [mmu_pkg::PADDR_W-1:0]   l1_addr;
    logic [mmu_pkg::PADDR_W-1:0]   l0_addr;

    assign rd_pte  = mem_rdata;
    assign rd_bad  = !rd_pte.v || (rd_pte.w && !rd_pte.r);   // Invalid or reserved w without r
    assign rd_leaf = rd_pte.r || rd_pte.x;

    // Level 1 leaf must be aligned to 4M, level 0 must be a leaf
    assign walk_fail = (state_q == WAIT_L1) ? (rd_bad || (rd_leaf && (rd_pte.ppn_0 != '0)))
                                            : (rd_bad || !rd_leaf);
    assign descend   = (state_q == WAIT_L1) && !rd_bad && !rd_leaf;
    assign start     = (state_q == IDLE) && walk_start;

    assign l1_addr = {satp_ppn, walk_req.vpn[19:10], 2'b00};
    assign l0_addr = {rd_pte.ppn_1, rd_pte.ppn_0, vpn_q[9:0], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            mem_req_q <= 1'b0;
            done_q    <= 1'b0;
            update_q  <= 1'b0;
        end else begin
            mem_req_q <= 1'b0;     // All three are single cycle pulses
            done_q    <= 1'b0;
            update_q  <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (walk_start) begin
                        mem_req_q <= 1'b1;
                        state_q   <= WAIT_L1;
                    end
                end
                WAIT_L1, WAIT_L0: begin
                    if (mem_rvalid) begin
                        if (descend) begin
                            mem_req_q <= 1'b1;
                            state_q   <= WAIT_L0;
                        end else begin
                            done_q   <= 1'b1;
                            update_q <= !walk_fail;
                            state_q  <= IDLE;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            vpn_q      <= walk_req.vpn;
            mem_addr_q <= l1_addr[31:0];     // Upper two address bits dropped
        end else if (mem_rvalid && descend) begin
            mem_addr_q <= l0_addr[31:0];
        end
        if (mem_rvalid && (state_q != IDLE) && !descend) begin
            fault_q   <= walk_fail;
            pte_q     <= rd_pte;
            page_4m_q <= (state_q == WAIT_L1);
        end
    end

    // Read tracking for the protocol check
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_q) begin
            outstanding_q <= 1'b1;
        end else if (mem_rvalid) begin
            outstanding_q <= 1'b0;
        end
    end

    assign mem_req  = mem_req_q;
    assign mem_addr = mem_addr_q;

    assign walk_rsp.done    = done_q;
    assign walk_rsp.fault   = fault_q;
    assign walk_rsp.pte     = pte_q;
    assign walk_rsp.page_4M = page_4m_q;

    assign tlb_update       = update_q;
    assign ptw2tlb.vpn      = vpn_q;
    assign ptw2tlb.pte      = pte_q;
    assign ptw2tlb.page_4M  = page_4m_q;

    one_read_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req |-> !outstanding_q
    );

endmodule

//--- design/xlate_check_stage.sv
module xlate_check_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                priv_user,

    input  logic                check_valid,
    input  mmu_pkg::check_in_s  check_in,

    output logic                rsp_valid,
    output mmu_pkg::xlate_rsp_s rsp_data
);

    mmu_pkg::pte_s                pte;
    mmu_pkg::fault_cause_e        cause;
    logic                         fault;
    logic [mmu_pkg::PADDR_W-1:0]  paddr;

    assign pte = check_in.pte;

    // First matching rule wins
    always_comb begin
        if (check_in.walk_fault) begin
            cause = mmu_pkg::CAUSE_WALK;
        end else if (!pte.x || !pte.a) begin
            cause = mmu_pkg::CAUSE_EXEC;       // No hardware A update, so a clear A faults
        end else if (pte.u != priv_user) begin
            cause = mmu_pkg::CAUSE_USER;
        end else begin
            cause = mmu_pkg::CAUSE_NONE;
        end
    end

    assign fault = (cause != mmu_pkg::CAUSE_NONE);

    always_comb begin
        if (fault) begin
            paddr = '0;
        end else if (check_in.page_4M) begin
            paddr = {pte.ppn_1, check_in.vaddr[21:0]};
        end else begin
            paddr = {pte.ppn_1, pte.ppn_0, check_in.vaddr[mmu_pkg::PAGE_OFFSET_W-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= check_valid;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (check_valid) begin
            rsp_data.tag         <= check_in.tag;
            rsp_data.paddr       <= paddr;
            rsp_data.page_fault  <= fault;
            rsp_data.fault_cause <= cause;
        end
    end

endmodule

//--- design/xlate_lookup_stage.sv
module xlate_lookup_stage (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                req,
    input  mmu_pkg::xlate_req_s req_data,
    output logic                ready,
    input  logic                flush,

    // Walker side
    output logic                walk_start,
    output mmu_pkg::walk_req_s  walk_req,
    input  mmu_pkg::walk_rsp_s  walk_rsp,
    input  logic                tlb_update,
    input  mmu_pkg::ptw2tlb_s   ptw2tlb,

    // Towards the check stage
    output logic                check_valid,
    output mmu_pkg::check_in_s  check_in
);

    mmu_pkg::xlate_req_s req_q;
    logic                valid_q;
    logic                pending_q;    // Walk issued and not yet answered
    mmu_pkg::mmu2tlb_s   mmu2tlb;
    mmu_pkg::tlb2mmu_s   tlb2mmu;
    logic                hit;
    logic                walk_fault_done;
    logic                forward;
    logic                accept;

    // No probe while the walker owns the request
    assign mmu2tlb.vpage_addr = req_q.vaddr[31:mmu_pkg::PAGE_OFFSET_W];
    assign mmu2tlb.tlb_req    = valid_q && !pending_q;
    assign mmu2tlb.tlb_flush  = flush;

    itlb itlb_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ptw2tlb    (ptw2tlb),
        .tlb_update (tlb_update),
        .mmu2tlb    (mmu2tlb),
        .tlb2mmu    (tlb2mmu)
    );

    assign hit             = tlb2mmu.hit;
    assign walk_fault_done = pending_q && walk_rsp.done && walk_rsp.fault;
    assign forward         = hit || walk_fault_done;
    assign ready           = !valid_q || forward;    // Refill in the cycle a request leaves
    assign accept          = req && ready;

    assign walk_start   = valid_q && !pending_q && !hit;
    assign walk_req.vpn = req_q.vaddr[31:mmu_pkg::PAGE_OFFSET_W];

    assign check_valid         = forward;
    assign check_in.vaddr      = req_q.vaddr;
    assign check_in.tag        = req_q.tag;
    assign check_in.pte        = walk_fault_done ? walk_rsp.pte : tlb2mmu.pte;
    assign check_in.page_4M    = walk_fault_done ? walk_rsp.page_4M : tlb2mmu.page_4M;
    assign check_in.walk_fault = walk_fault_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
            end else if (forward) begin
                valid_q <= 1'b0;
            end
            // After a good walk the probe replays next cycle
            if (walk_start) begin
                pending_q <= 1'b1;
            end else if (walk_rsp.done) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_data;
        end
    end

    done_only_when_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        walk_rsp.done |-> pending_q
    );

endmodule

//--- dv/mmu_tb.sv
module mmu_tb;

    localparam int NUM_REQS = 75;
    localparam int TIMEOUT  = NUM_REQS * 20 + 200;
    localparam logic [21:0] SATP = 22'h00100;

    typedef struct packed {
        logic [3:0]  tag;
        logic [33:0] paddr;
        logic        fault;
        logic [1:0]  cause;
        logic        hit;
    } exp_s;

    logic                clk;
    logic                rst_n;
    logic                req;
    mmu_pkg::xlate_req_s req_data;
    logic                ready;
    logic                flush;
    logic [21:0]         satp_ppn;
    logic                priv_user;
    logic                mem_req;
    logic [31:0]         mem_addr;
    logic                mem_rvalid;
    logic [31:0]         mem_rdata;
    logic                rsp_valid;
    mmu_pkg::xlate_rsp_s rsp_data;

    exp_s        exp_q[$];
    int          acc_q[$];
    logic [31:0] addr_q[$];
    int          cycle;
    int          errors;
    int          test_errors;
    int          exp_reads;
    int          mem_reads;
    int          test_reqs;
    int          tests_run;
    logic [3:0]  tag_cnt;
    logic        prev_hit;
    logic [31:0] va_list[4];

    // Shadow of the direct-mapped iTLB
    logic        sh_valid[4];
    logic [19:0] sh_vpn[4];
    logic        sh_4m[4];

    mmu_top mmu_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_data   (req_data),
        .ready      (ready),
        .flush      (flush),
        .satp_ppn   (satp_ppn),
        .priv_user  (priv_user),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    pt_mem_model mem_model_inst (
        .clk        (clk),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle > TIMEOUT) begin
            $display("Timeout after %0d cycles, results still outstanding", cycle);
            $display("Errors found");
            $finish;
        end
    end

    function automatic void fail_check();
        errors++;
        test_errors++;
    endfunction

    // Outputs are sampled mid cycle away from both edges
    always @(negedge clk) begin
        exp_s        e;
        int          acc;
        logic [31:0] exp_addr;
        if (mem_req) begin
            mem_reads++;
            if (addr_q.size() == 0) begin
                $display("mem_req issued with no page table read expected");
                fail_check();
            end else begin
                exp_addr = addr_q.pop_front();
                if (mem_addr != exp_addr) begin
                    $display("mismatch mem_addr: got %h expected %h", mem_addr, exp_addr);
                    fail_check();
                end
            end
        end
        if (rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("rsp_valid came with no request outstanding");
                fail_check();
            end else begin
                e   = exp_q.pop_front();
                acc = acc_q.pop_front();
                if (rsp_data.tag != e.tag) begin
                    $display("mismatch rsp_data.tag: got %h expected %h", rsp_data.tag, e.tag);
                    fail_check();
                end
                if (rsp_data.paddr != e.paddr) begin
                    $display("mismatch rsp_data.paddr: got %h expected %h (tag %h)",
                             rsp_data.paddr, e.paddr, e.tag);
                    fail_check();
                end
                if (rsp_data.page_fault != e.fault) begin
                    $display("mismatch rsp_data.page_fault: got %h expected %h (tag %h)",
                             rsp_data.page_fault, e.fault, e.tag);
                    fail_check();
                end
                if (rsp_data.fault_cause != e.cause) begin
                    $display("mismatch rsp_data.fault_cause: got %h expected %h (tag %h)",
                             rsp_data.fault_cause, e.cause, e.tag);
                    fail_check();
                end
                if (e.hit && (cycle - acc != 2)) begin
                    $display("Hit result for tag %h came %0d cycles after acceptance, not 2",
                             e.tag, cycle - acc);
                    fail_check();
                end
            end
        end
    end

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] make_va(input int vpn_1, input int vpn_0);
        logic [31:0] rnd;
        rnd = $urandom;
        return {vpn_1[9:0], vpn_0[9:0], rnd[11:0]};
    endfunction

    // Random leaf with execute, accessed and user bits picked at random
    function automatic logic [31:0] perm_leaf();
        logic [31:0] rnd;
        rnd = $urandom;
        return make_pte(rnd[31:10], {1'b0, rnd[0], 1'b0, rnd[1], rnd[2], 1'b0, 1'b1, 1'b1});
    endfunction

    task automatic build_tables();
        logic [31:0] rnd;
        mem_model_inst.write_word(32'h0010_0000, make_pte(22'h00200, 8'h01));    // To L0 table
        mem_model_inst.write_word(32'h0010_0004, make_pte(22'h00201, 8'h01));
        for (int i = 2; i < 4; i++) begin
            rnd = $urandom;
            mem_model_inst.write_word(32'h0010_0000 + 32'(i * 4),
                                      make_pte({rnd[11:0], 10'h0}, 8'h4b));
        end
        rnd = $urandom;
        mem_model_inst.write_word(32'h0010_0010, make_pte({rnd[11:0], 10'h1 | rnd[21:12]}, 8'h4b));
        mem_model_inst.write_word(32'h0010_0014, 32'h0);
        mem_model_inst.write_word(32'h0010_0018, make_pte(22'h00300, 8'h4d));    // w without r
        for (int i = 0; i < 4; i++) begin
            rnd = $urandom;
            mem_model_inst.write_word(32'h0020_0000 + 32'(i * 4), make_pte(rnd[21:0], 8'h4b));
        end
        mem_model_inst.write_word(32'h0020_0010, 32'h0);
        mem_model_inst.write_word(32'h0020_0014, make_pte(22'h00305, 8'h4d));
        mem_model_inst.write_word(32'h0020_0018, make_pte(22'h00306, 8'h01));    // Pointer at level 0
        mem_model_inst.write_word(32'h0020_001c, perm_leaf());
        for (int i = 0; i < 8; i++) begin
            mem_model_inst.write_word(32'h0020_1000 + 32'(i * 4), perm_leaf());
        end
    endtask

    // Entered and left 1 unit after a rising edge
    task automatic send(input logic [31:0] va);
        exp_s        e;
        int          reads;
        int          stalls;
        logic        refill;
        logic [31:0] l1_addr;
        logic [31:0] l0_addr;
        logic [19:0] vpn;
        logic [1:0]  idx;
        mem_model_inst.ref_walk(satp_ppn, va, priv_user, e.paddr, e.fault, e.cause, reads,
                                refill, l1_addr, l0_addr);
        vpn   = va[31:12];
        idx   = vpn[1:0];
        e.tag = tag_cnt;
        e.hit = sh_valid[idx] && (sh_vpn[idx][19:10] == vpn[19:10]) &&
                (sh_4m[idx] || (sh_vpn[idx][9:0] == vpn[9:0]));
        if (!e.hit) begin
            exp_reads += reads;
            addr_q.push_back(l1_addr);
            if (reads == 2) begin
                addr_q.push_back(l0_addr);
            end
            if (refill) begin
                sh_valid[idx] = 1'b1;
                sh_vpn[idx]   = vpn;
                sh_4m[idx]    = (reads == 1);
            end
        end
        exp_q.push_back(e);
        req      = 1'b1;
        req_data = {va, tag_cnt};
        stalls   = 0;
        @(negedge clk);
        while (!ready) begin
            stalls++;
            @(negedge clk);
        end
        acc_q.push_back(cycle);
        if (prev_hit && stalls != 0) begin
            $display("ready was low for %0d cycles behind a TLB hit (tag %h)", stalls, tag_cnt);
            fail_check();
        end
        prev_hit = e.hit;
        tag_cnt++;
        test_reqs++;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic do_flush();
        drain();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int i = 0; i < 4; i++) begin
            sh_valid[i] = 1'b0;
        end
    endtask

    task automatic start_test();
        test_errors = 0;
        exp_reads   = 0;
        mem_reads   = 0;
        test_reqs   = 0;
        addr_q.delete();
    endtask

    task automatic end_test(input int num, input string name);
        drain();
        if (mem_reads != exp_reads) begin
            $display("mismatch mem_req count: got %h expected %h", mem_reads, exp_reads);
            fail_check();
        end
        tests_run++;
        $display("test %0d %s: %0d requests, %0d errors", num, name, test_reqs, test_errors);
    endtask

    initial begin
        void'($urandom(32'h1361_673f));
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        flush     = 1'b0;
        satp_ppn  = SATP;
        priv_user = 1'b0;
        cycle     = 0;
        errors    = 0;
        tests_run = 0;
        tag_cnt   = 4'h0;
        prev_hit  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            sh_valid[i] = 1'b0;
            sh_vpn[i]   = 20'h0;
            sh_4m[i]    = 1'b0;
        end
        build_tables();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test();
        for (int i = 0; i < 4; i++) begin
            va_list[i] = make_va(0, i);
        end
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 4; i++) begin
                send(va_list[i]);
            end
        end
        for (int i = 0; i < 4; i++) begin
            send(va_list[$urandom_range(3, 0)]);
        end
        end_test(1, "4K pages");

        start_test();
        for (int i = 0; i < 8; i++) begin
            send(make_va(2 + (i % 2), $urandom_range(1023, 0)));
        end
        send(make_va(4, 0));
        send(make_va(4, 0));
        end_test(2, "4M superpages");

        start_test();
        send(make_va(5, 3));
        send(make_va(5, 3));
        send(make_va(6, 1));
        send(make_va(6, 1));
        for (int i = 4; i < 7; i++) begin
            send(make_va(0, i));
            send(make_va(0, i));
        end
        end_test(3, "walk faults");

        start_test();
        for (int u = 0; u < 2; u++) begin
            drain();
            priv_user = u[0];
            for (int i = 0; i < 8; i++) begin
                send(make_va(1, i));
            end
        end
        drain();
        priv_user = 1'b0;
        end_test(4, "permission faults");

        start_test();
        send(make_va(0, 0));
        send(make_va(2, 0));    // Same index so the 4K entry is evicted
        send(make_va(0, 0));
        do_flush();
        send(make_va(2, 0));
        send(make_va(0, 1));
        send(make_va(0, 1));
        do_flush();
        send(make_va(0, 1));
        end_test(5, "flush and conflict");

        start_test();
        for (int i = 0; i < 4; i++) begin
            send(va_list[i]);
        end
        drain();
        for (int i = 0; i < 16; i++) begin
            send(va_list[$urandom_range(3, 0)]);
        end
        end_test(6, "back-to-back hits");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dv/pt_mem_model.sv
module pt_mem_model (
    input  logic        clk,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_rvalid,
    output logic [31:0] mem_rdata
);

    logic [31:0] words [logic [31:0]];    // Sparse page table storage
    logic        busy;
    logic [31:0] rd_addr;
    int          delay;

    initial begin
        mem_rvalid = 1'b0;
        mem_rdata  = 32'h0;
        busy       = 1'b0;
        rd_addr    = 32'h0;
        delay      = 0;
    end

    function automatic void write_word(input logic [31:0] addr, input logic [31:0] data);
        words[addr] = data;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return 32'h0;    // Unwritten words read as invalid PTEs
    endfunction

    // Expected outcome of a fetch under the Sv32 walk and the execute and user rules
    function automatic void ref_walk(
        input  logic [21:0] satp_ppn,
        input  logic [31:0] vaddr,
        input  logic        priv_user,
        output logic [33:0] paddr,
        output logic        fault,
        output logic [1:0]  cause,
        output int          reads,
        output logic        refill,
        output logic [31:0] l1_addr,
        output logic [31:0] l0_addr
    );
        logic [33:0] addr;
        logic [31:0] pte;
        logic        walk_bad;
        logic        leaf_4m;
        addr     = {satp_ppn, vaddr[31:22], 2'b00};
        l1_addr  = addr[31:0];
        l0_addr  = 32'h0;
        pte      = read_word(addr[31:0]);
        reads    = 1;
        leaf_4m  = 1'b0;
        walk_bad = 1'b0;
        if (!pte[0] || (pte[2] && !pte[1])) begin
            walk_bad = 1'b1;
        end else if (pte[1] || pte[3]) begin
            leaf_4m  = 1'b1;
            walk_bad = (pte[19:10] != 10'h0);    // Superpage must be aligned
        end else begin
            addr    = {pte[31:10], vaddr[21:12], 2'b00};
            l0_addr = addr[31:0];
            pte     = read_word(addr[31:0]);
            reads   = 2;
            if (!pte[0] || (pte[2] && !pte[1]) || !(pte[1] || pte[3])) begin
                walk_bad = 1'b1;
            end
        end
        refill = !walk_bad;
        if (walk_bad) begin
            cause = 2'd1;
        end else if (!pte[3] || !pte[6]) begin
            cause = 2'd2;
        end else if (pte[4] != priv_user) begin
            cause = 2'd3;
        end else begin
            cause = 2'd0;
        end
        fault = (cause != 2'd0);
        if (fault) begin
            paddr = 34'h0;
        end else if (leaf_4m) begin
            paddr = {pte[31:20], vaddr[21:0]};
        end else begin
            paddr = {pte[31:10], vaddr[11:0]};
        end
    endfunction

    always @(negedge clk) begin
        if (mem_req) begin
            busy    = 1'b1;
            rd_addr = mem_addr;
            delay   = $urandom_range(3, 0);
        end
    end

    // Answer 1 to 4 cycles after the request
    always @(posedge clk) begin
        #1;
        mem_rvalid = 1'b0;
        if (busy) begin
            if (delay == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = read_word(rd_addr);
                busy       = 1'b0;
            end else begin
                delay--;
            end
        end
    end

endmodule

//--- sim.f
design/mmu_pkg.sv
design/itlb.sv
design/xlate_lookup_stage.sv
design/ptw.sv
design/xlate_check_stage.sv
design/mmu_top.sv
dv/pt_mem_model.sv
dv/mmu_tb.sv
